//--- mips_settings.svh
//----------------------------------------
// sizes shared by the 8-bit mips core
// include in any file that needs a width
// or the pc value after reset
//----------------------------------------
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// data and address width in bits
`define MIPS_WIDTH 8

// eight registers, so three index bits
`define MIPS_REGBITS 3

// a 32-bit instruction arrives as four bytes
`define MIPS_INSTR_BYTES 4

`define MIPS_RESET_PC 0   // first fetch address

`endif

//--- mipsPkg.sv
//----------------------------------------
// types shared by the mips core modules
// import with mipsPkg::* in the module header
//----------------------------------------
`include "mips_settings.svh"

package mipsPkg;

   typedef logic [`MIPS_WIDTH-1:0]   dataT;     // data byte, also an address
   typedef logic [`MIPS_REGBITS-1:0] regIdxT;   // register number
   typedef logic [31:0]              instrT;    // assembled instruction word

   // opcode field, bits 31..26
   typedef enum logic [5:0] {
      opRtype = 6'h00,
      opJ     = 6'h02,
      opAddi  = 6'h08,
      opLb    = 6'h20,
      opSb    = 6'h28
   } opcodeT;

   // r-type funct field, bits 5..0
   typedef enum logic [5:0] {
      fnAdd = 6'h20,
      fnSub = 6'h22,
      fnAnd = 6'h24,
      fnOr  = 6'h25,
      fnSlt = 6'h2A
   } functT;

   // fetch states first so the low two bits give the byte index
   typedef enum logic [3:0] {
      sFetch1, sFetch2, sFetch3, sFetch4,
      sDecode, sMemAdr, sLbRd, sLbWr, sSbWr,
      sRtypeEx, sRtypeWr, sAddiEx, sAddiWr, sJumpEx
   } stateT;

   typedef enum logic       {srcAPc, srcARegA} srcAT;             // alu a operand
   typedef enum logic [1:0] {srcBRegB, srcBOne, srcBImm} srcBT;   // alu b operand
   typedef enum logic       {aluAdd, aluFunct} aluModeT;          // add or decode funct
   typedef enum logic       {pcFromAlu, pcFromJump} pcSrcT;       // next pc source

endpackage

//--- ctrlIf.sv
//----------------------------------------
// control bundle between the FSM and the
// datapath, ctrl side drives the selects
// and enables, dp side returns the opcode
//----------------------------------------
`timescale 1ns/1ps
`include "mips_settings.svh"

interface ctrlIf import mipsPkg::*; ();

   logic [`MIPS_INSTR_BYTES-1:0] irWrite;   // one-hot byte enable into the IR
   logic    pcEn;       // load pc
   logic    regWrite;   // register file write strobe
   logic    regDst;     // write register is rd instead of rt
   srcAT    srcA;
   srcBT    srcB;
   aluModeT aluMode;
   pcSrcT   pcSrc;
   logic    iOrD;       // memory address from aluOut instead of pc
   logic    memToReg;   // write back the memory data register

   opcodeT  op;         // opcode from the instruction register

   modport ctrl (
      output irWrite, pcEn, regWrite, regDst, srcA, srcB,
      output aluMode, pcSrc, iOrD, memToReg,
      input  op
   );

   modport dp (
      input  irWrite, pcEn, regWrite, regDst, srcA, srcB,
      input  aluMode, pcSrc, iOrD, memToReg,
      output op
   );

endinterface

//--- aluUnit.sv
//----------------------------------------
// ALU of the mips core
// add in aluAdd mode, otherwise the r-type
// funct field picks the operation
//----------------------------------------
`timescale 1ns/1ps
`include "mips_settings.svh"

module aluUnit import mipsPkg::*;
(
   input  dataT    a,
   input  dataT    b,
   input  aluModeT mode,
   input  functT   funct,
   output dataT    result
);

   dataT sum;
   dataT diff;
   dataT lessThan;

   assign sum  = a + b;   // wraps modulo 256
   assign diff = a - b;

   // slt looks only at the sign of the difference
   assign lessThan = {{(`MIPS_WIDTH-1){1'b0}}, diff[`MIPS_WIDTH-1]};

   always_comb
   begin
      if (mode == aluAdd)
         result = sum;   // address calc, addi, pc + 1
      else
      begin
         case (funct)
            fnAdd:   result = sum;
            fnSub:   result = diff;
            fnAnd:   result = a & b;
            fnOr:    result = a | b;
            fnSlt:   result = lessThan;
            default: result = '0;   // unsupported funct writes zero
         endcase
      end
   end

endmodule

//--- regFile.sv
//----------------------------------------
// eight-entry register file, two reads
// and one synchronous write
// register 0 is hardwired to zero
//----------------------------------------
`timescale 1ns/1ps
`include "mips_settings.svh"

module regFile import mipsPkg::*;
(
   input  logic   clk,
   input  logic   reset,
   input  logic   regWrite,
   input  regIdxT ra1,
   input  regIdxT ra2,
   input  regIdxT wa,
   input  dataT   wd,
   output dataT   rd1,
   output dataT   rd2
);

   localparam int NumRegs = 1 << `MIPS_REGBITS;

   dataT regs [NumRegs];

   always_ff @(posedge clk)
   begin
      if (!reset)
      begin
         for (int i = 0; i < NumRegs; i++)
            regs[i] <= '0;   // whole file clears
      end
      else if (regWrite)
         regs[wa] <= wd;
   end

   // combinational reads, entry 0 masked regardless of contents
   assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
   assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

   waKnown: assert property (@(posedge clk) disable iff (!reset)
      regWrite |-> !$isunknown(wa));

endmodule

//--- datapath.sv
//----------------------------------------
// datapath of the mips core
// IR, pc, mdr, operand latches, aluOut and
// the selects, steered by the FSM over ctrlIf
//----------------------------------------
`timescale 1ns/1ps
`include "mips_settings.svh"

module datapath import mipsPkg::*;
(
   input  logic clk,
   input  logic reset,
   input  dataT memData,
   output dataT adr,
   output dataT writeData,
   ctrlIf.dp    bus
);

   instrT  instr;       // four byte registers side by side
   dataT   pc;
   dataT   nextPc;
   dataT   mdr;         // memory data register
   dataT   regA;
   dataT   regB;
   dataT   aluOut;
   dataT   aluResult;
   dataT   aluA;
   dataT   aluB;
   dataT   rd1;
   dataT   rd2;
   dataT   imm;
   dataT   jumpTarget;
   dataT   writeVal;
   regIdxT rs;
   regIdxT rt;
   regIdxT rd;
   regIdxT writeReg;

   // ----------------------------------------
   // instruction fields
   // ----------------------------------------
   assign bus.op     = opcodeT'(instr[31:26]);
   assign rs         = instr[23:21];
   assign rt         = instr[18:16];
   assign rd         = instr[13:11];
   assign imm        = instr[7:0];
   assign jumpTarget = {instr[5:0], 2'b00};   // word index to byte address

   // ----------------------------------------
   // control state registers
   // ----------------------------------------
   always_ff @(posedge clk)
   begin
      if (!reset)
      begin
         instr <= '0;
         pc    <= dataT'(`MIPS_RESET_PC);
      end
      else
      begin
         for (int i = 0; i < `MIPS_INSTR_BYTES; i++)
            if (bus.irWrite[i])
               instr[i*`MIPS_WIDTH +: `MIPS_WIDTH] <= memData;   // lowest byte first
         if (bus.pcEn)
            pc <= nextPc;
      end
   end

   // payload registers load every cycle
   always_ff @(posedge clk)
   begin
      mdr    <= memData;
      regA   <= rd1;
      regB   <= rd2;
      aluOut <= aluResult;
   end

   // ----------------------------------------
   // selects
   // ----------------------------------------
   assign adr       = bus.iOrD ? aluOut : pc;
   assign writeData = regB;   // sb stores rt
   assign writeReg  = bus.regDst ? rd : rt;
   assign writeVal  = bus.memToReg ? mdr : aluOut;
   assign nextPc    = (bus.pcSrc == pcFromJump) ? jumpTarget : aluResult;
   assign aluA      = (bus.srcA == srcARegA) ? regA : pc;

   always_comb
   begin
      case (bus.srcB)
         srcBRegB: aluB = regB;
         srcBOne:  aluB = dataT'(1);   // pc step of one byte
         srcBImm:  aluB = imm;
         default:  aluB = '0;
      endcase
   end

   regFile rf0 (
      .clk      (clk),
      .reset    (reset),
      .regWrite (bus.regWrite),
      .ra1      (rs),
      .ra2      (rt),
      .wa       (writeReg),
      .wd       (writeVal),
      .rd1      (rd1),
      .rd2      (rd2)
   );

   aluUnit alu0 (
      .a      (aluA),
      .b      (aluB),
      .mode   (bus.aluMode),
      .funct  (functT'(instr[5:0])),
      .result (aluResult)
   );

   // the pc must not move while memory is addressed by aluOut
   pcNotDataCycle: assert property (@(posedge clk) disable iff (!reset)
      !(bus.pcEn && bus.iOrD));

endmodule

//--- mainController.sv
//----------------------------------------
// multicycle FSM of the mips core
// four fetch cycles, decode, then one to
// three execute cycles per instruction
//----------------------------------------
`timescale 1ns/1ps

module mainController import mipsPkg::*;
(
   input  logic clk,
   input  logic reset,
   output logic memWrite,
   ctrlIf.ctrl  bus
);

   stateT state;
   stateT nextState;

   // ----------------------------------------
   // state register
   // ----------------------------------------
   always_ff @(posedge clk)
   begin
      if (!reset)
         state <= sFetch1;
      else
         state <= nextState;
   end

   // next state, only decode and address look at the opcode
   always_comb
   begin
      nextState = sFetch1;
      case (state)
         sFetch1:  nextState = sFetch2;
         sFetch2:  nextState = sFetch3;
         sFetch3:  nextState = sFetch4;
         sFetch4:  nextState = sDecode;
         sDecode:
         begin
            case (bus.op)
               opAddi:     nextState = sAddiEx;
               opLb, opSb: nextState = sMemAdr;
               opRtype:    nextState = sRtypeEx;
               opJ:        nextState = sJumpEx;
               default:    nextState = sFetch1;   // unknown opcode is a no-op
            endcase
         end
         sMemAdr:  nextState = (bus.op == opLb) ? sLbRd : sSbWr;
         sLbRd:    nextState = sLbWr;
         sRtypeEx: nextState = sRtypeWr;
         sAddiEx:  nextState = sAddiWr;
         default:  nextState = sFetch1;   // write states and jump end here
      endcase
   end

   // ----------------------------------------
   // output decode
   // ----------------------------------------
   always_comb
   begin
      // everything idle unless the state asks for it
      bus.irWrite  = '0;
      bus.pcEn     = 1'b0;
      bus.regWrite = 1'b0;
      bus.regDst   = 1'b0;
      bus.srcA     = srcAPc;
      bus.srcB     = srcBRegB;
      bus.aluMode  = aluAdd;
      bus.pcSrc    = pcFromAlu;
      bus.iOrD     = 1'b0;
      bus.memToReg = 1'b0;
      memWrite     = 1'b0;
      case (state)
         sFetch1, sFetch2, sFetch3, sFetch4:
         begin
            bus.irWrite[state[1:0]] = 1'b1;   // byte n of the word
            bus.srcB = srcBOne;               // pc + 1
            bus.pcEn = 1'b1;
         end
         sMemAdr, sAddiEx:
         begin
            bus.srcA = srcARegA;   // base + imm
            bus.srcB = srcBImm;
         end
         sLbRd:
            bus.iOrD = 1'b1;   // mdr catches memData at the edge
         sLbWr:
         begin
            bus.regWrite = 1'b1;
            bus.memToReg = 1'b1;
         end
         sSbWr:
         begin
            bus.iOrD = 1'b1;
            memWrite = 1'b1;
         end
         sRtypeEx:
         begin
            bus.srcA    = srcARegA;
            bus.aluMode = aluFunct;
         end
         sRtypeWr:
         begin
            bus.regDst   = 1'b1;
            bus.regWrite = 1'b1;
         end
         sAddiWr:
            bus.regWrite = 1'b1;   // rt gets aluOut
         sJumpEx:
         begin
            bus.pcEn  = 1'b1;
            bus.pcSrc = pcFromJump;
         end
         default: ;
      endcase
   end

   // ----------------------------------------
   // checks
   // ----------------------------------------
   memWriteOnlySb: assert property (@(posedge clk) disable iff (!reset)
      memWrite |-> state == sSbWr);

   irWriteOneHot: assert property (@(posedge clk) disable iff (!reset)
      $onehot0(bus.irWrite));

   stateLegal: assert property (@(posedge clk) disable iff (!reset)
      state inside {sFetch1, sFetch2, sFetch3, sFetch4, sDecode, sMemAdr,
                    sLbRd, sLbWr, sSbWr, sRtypeEx, sRtypeWr, sAddiEx,
                    sAddiWr, sJumpEx});

endmodule

//--- miniMips.sv
//----------------------------------------
// top level of the 8-bit mips core
// memory is external, reads are combinational,
// writes happen on the edge with memWrite high
//----------------------------------------
`timescale 1ns/1ps

module miniMips import mipsPkg::*;
(
   input  logic clk,
   input  logic reset,       // synchronous, active low
   input  dataT memData,     // byte at adr
   output logic memWrite,
   output dataT adr,
   output dataT writeData
);

   ctrlIf bus0 ();

   // FSM, drives memWrite directly
   mainController ctrl0 (
      .clk      (clk),
      .reset    (reset),
      .memWrite (memWrite),
      .bus      (bus0)
   );

   datapath dp0 (
      .clk       (clk),
      .reset     (reset),
      .memData   (memData),
      .adr       (adr),
      .writeData (writeData),
      .bus       (bus0)
   );

endmodule

//--- tbMiniMips.sv
//----------------------------------------
// testbench for the 8-bit mips core
// models the byte memory, runs short programs
// and checks every store against an
// instruction-level reference model
//----------------------------------------
`timescale 1ns/1ps

module tbMiniMips import mipsPkg::*; ();

   localparam int WaitLimit    = 3000;   // cycles allowed per program
   localparam int SettleCycles = 60;     // quiet time after the last store
   localparam int MaxSteps     = 500;

   logic clk;
   logic reset;
   dataT memData;
   logic memWrite;
   dataT adr;
   dataT writeData;

   dataT mem [256] = '{default: '0};
   dataT image [256];                    // memory contents for the next run
   logic loadReq;
   dataT logAdr [256];                   // stores seen from the DUT
   dataT logData [256];
   int   storeCount = 0;

   logic [31:0] prog [256];
   int   progLen;
   dataT expAdr [256];                   // stores predicted by refRun
   dataT expData [256];
   int   expCount;

   integer seed;
   int   errCount;
   int   passCount;
   int   failCount;
   int   testNum;

   miniMips dut0 (
      .clk       (clk),
      .reset     (reset),
      .memData   (memData),
      .memWrite  (memWrite),
      .adr       (adr),
      .writeData (writeData)
   );

   always #20 clk = ~clk;   // 40 ns period

   // ----------------------------------------
   // memory model
   // ----------------------------------------
   assign memData = mem[adr];   // combinational read

   always @(posedge clk)
   begin
      if (loadReq)
      begin
         for (int i = 0; i < 256; i++)
            mem[dataT'(i)] <= image[dataT'(i)];
         storeCount <= 0;
      end
      else if (memWrite === 1'b1)
      begin
         mem[adr] <= writeData;
         logAdr[dataT'(storeCount)]  <= adr;
         logData[dataT'(storeCount)] <= writeData;
         storeCount <= storeCount + 1;
      end
   end

   // ----------------------------------------
   // program building
   // ----------------------------------------
   function automatic logic [31:0] encI(opcodeT op, int rs, int rt, dataT imm);
      return {op, 2'b00, 3'(rs), 2'b00, 3'(rt), 8'h00, imm};
   endfunction

   function automatic logic [31:0] encR(logic [5:0] fn, int rd, int rs, int rt);
      return {opRtype, 2'b00, 3'(rs), 2'b00, 3'(rt), 2'b00, 3'(rd), 5'b00000, fn};
   endfunction

   function automatic logic [31:0] encJ(int target);
      return {opJ, 20'h00000, 6'(target)};   // word index
   endfunction

   function automatic void emit(logic [31:0] word);
      prog[dataT'(progLen)] = word;
      progLen++;
   endfunction

   function automatic void halt();
      emit(encJ(progLen));   // jump to itself
   endfunction

   function automatic dataT randByte();
      return dataT'($random(seed));
   endfunction

   function automatic void newProgram();
      progLen = 0;
      for (int a = 0; a < 256; a++)
         image[dataT'(a)] = dataT'(a) ^ 8'hA5;   // fill follows the address
   endfunction

   // ----------------------------------------
   // instruction-level reference model
   // ----------------------------------------
   function automatic int refRun();
      dataT m [256];
      dataT r [8];
      dataT pc;
      dataT here;
      dataT a;
      dataT b;
      dataT res;
      logic [31:0] w;
      logic done;
      int n;
      n = 0;
      pc = '0;
      done = 1'b0;
      for (int i = 0; i < 256; i++)
         m[dataT'(i)] = image[dataT'(i)];
      for (int i = 0; i < 8; i++)
         r[i] = '0;
      for (int steps = 0; steps < MaxSteps && !done; steps++)
      begin
         here = pc;
         w = {m[pc + 8'd3], m[pc + 8'd2], m[pc + 8'd1], m[pc]};   // low byte first
         pc = pc + 8'd4;
         a = r[w[23:21]];
         b = r[w[18:16]];
         case (w[31:26])
            opAddi: r[w[18:16]] = a + w[7:0];
            opLb:   r[w[18:16]] = m[dataT'(a + w[7:0])];
            opSb:
            begin
               m[dataT'(a + w[7:0])] = b;
               expAdr[dataT'(n)]  = a + w[7:0];
               expData[dataT'(n)] = b;
               n++;
            end
            opRtype:
            begin
               case (w[5:0])
                  fnAdd: res = a + b;
                  fnSub: res = a - b;
                  fnAnd: res = a & b;
                  fnOr:  res = a | b;
                  fnSlt:
                  begin
                     res = a - b;
                     res = {7'b0000000, res[7]};   // sign of the difference
                  end
                  default: res = '0;
               endcase
               r[w[13:11]] = res;
            end
            opJ:
            begin
               pc = {w[5:0], 2'b00};
               done = (pc == here);   // self loop ends the program
            end
            default: ;   // unknown opcode does nothing
         endcase
         r[0] = '0;
      end
      return n;
   endfunction

   task automatic checkVal(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("ERR %s got %0h expected %0h", name, got, exp);
         errCount++;
      end
   endtask

   // ----------------------------------------
   // one program: load, reset, wait, compare
   // ----------------------------------------
   task automatic runTest(input string name);
      int errBefore;
      int cycles;
      errBefore = errCount;
      testNum++;
      for (int i = 0; i < progLen; i++)
         for (int b = 0; b < 4; b++)
            image[dataT'(4*i + b)] = dataT'(prog[dataT'(i)] >> (8*b));
      expCount = refRun();
      @(posedge clk);
      reset   <= 1'b0;
      loadReq <= 1'b1;
      @(posedge clk);
      loadReq <= 1'b0;
      repeat (15) @(posedge clk);
      reset <= 1'b1;
      @(negedge clk);   // first fetch cycle
      checkVal("memWrite", 32'(memWrite), 32'd0);
      checkVal("adr", 32'(adr), 32'd0);
      cycles = 0;
      while (storeCount < expCount && cycles < WaitLimit)
      begin
         @(posedge clk);
         cycles++;
      end
      if (storeCount < expCount)
      begin
         $display("test %0d %s: timed out, only %0d of %0d stores arrived",
                  testNum, name, storeCount, expCount);
         errCount++;
      end
      else
      begin
         repeat (SettleCycles) @(posedge clk);   // catches a stray store
         checkVal("storeCount", 32'(storeCount), 32'(expCount));
         for (int i = 0; i < expCount; i++)
         begin
            checkVal($sformatf("adr[%0d]", i), 32'(logAdr[dataT'(i)]),
                     32'(expAdr[dataT'(i)]));
            checkVal($sformatf("writeData[%0d]", i), 32'(logData[dataT'(i)]),
                     32'(expData[dataT'(i)]));
         end
      end
      if (errCount != errBefore)
      begin
         failCount++;
         $display("test %0d %s: failed", testNum, name);
      end
      else
      begin
         passCount++;
         $display("test %0d %s: ok, %0d stores", testNum, name, expCount);
      end
   endtask

   initial
   begin
      clk       = 1'b0;
      reset     = 1'b0;
      loadReq   = 1'b0;
      seed      = 32'h570a86b6;
      errCount  = 0;
      passCount = 0;
      failCount = 0;
      testNum   = 0;

      newProgram();   // idle loop, nothing stored
      halt();
      runTest("reset");

      newProgram();
      for (int r = 1; r < 8; r++)
         emit(encI(opAddi, 0, r, randByte()));
      emit(encI(opAddi, 3, 3, randByte()));   // chained onto r3
      for (int r = 1; r < 8; r++)
         emit(encI(opSb, 0, r, dataT'(8'h80 + r)));
      halt();
      runTest("addi sb");

      newProgram();
      emit(encI(opAddi, 0, 1, randByte()));
      emit(encI(opAddi, 0, 2, randByte()));
      emit(encI(opAddi, 0, 3, 8'h80));   // most negative
      emit(encI(opAddi, 0, 4, 8'h01));
      emit(encI(opAddi, 0, 6, 8'h7F));
      emit(encR(fnAdd, 5, 1, 2));
      emit(encI(opSb, 0, 5, 8'h90));
      emit(encR(fnSub, 5, 1, 2));
      emit(encI(opSb, 0, 5, 8'h91));
      emit(encR(fnAnd, 5, 1, 2));
      emit(encI(opSb, 0, 5, 8'h92));
      emit(encR(fnOr, 5, 1, 2));
      emit(encI(opSb, 0, 5, 8'h93));
      emit(encR(fnSlt, 5, 1, 2));
      emit(encI(opSb, 0, 5, 8'h94));
      emit(encR(fnSlt, 5, 2, 1));
      emit(encI(opSb, 0, 5, 8'h95));
      emit(encR(fnSlt, 5, 3, 4));   // difference wraps positive
      emit(encI(opSb, 0, 5, 8'h96));
      emit(encR(fnSlt, 5, 4, 3));
      emit(encI(opSb, 0, 5, 8'h97));
      emit(encR(fnSlt, 5, 3, 6));
      emit(encI(opSb, 0, 5, 8'h98));
      emit(encR(fnSub, 5, 3, 4));
      emit(encI(opSb, 0, 5, 8'h99));
      emit(encR(6'h27, 5, 1, 2));   // funct outside the set gives zero
      emit(encI(opSb, 0, 5, 8'h9A));
      halt();
      runTest("rtype");

      newProgram();
      for (int i = 0; i < 8; i++)
         image[dataT'(8'hC0 + i)] = randByte();   // data block
      emit(encI(opAddi, 0, 1, 8'hC0));
      emit(encI(opAddi, 0, 7, 8'hF0));
      emit(encI(opLb, 1, 2, 8'h00));
      emit(encI(opLb, 1, 3, 8'h03));
      emit(encI(opLb, 1, 4, 8'h05));
      emit(encI(opLb, 0, 5, 8'hC7));
      emit(encI(opLb, 7, 6, 8'hD2));   // F0 + D2 wraps to C2
      for (int r = 2; r < 7; r++)
         emit(encI(opSb, 0, r, dataT'(8'hA0 + r)));
      halt();
      runTest("lb round trip");

      newProgram();
      emit(encI(opAddi, 0, 0, 8'h3C));   // lost, r0 stays zero
      emit(encI(opSb, 0, 0, 8'hB0));
      emit(encI(opAddi, 0, 1, randByte() | 8'h01));
      emit(encR(fnAdd, 0, 1, 1));
      emit(encI(opSb, 0, 0, 8'hB1));
      emit(32'hFC21_0855);   // opcode 3F, rs rt rd all r1, must leave r1 alone
      emit(encJ(progLen + 2));
      emit(encI(opSb, 0, 1, 8'hBE));   // jumped over
      emit(encI(opSb, 0, 1, 8'hB2));
      halt();
      runTest("jump r0");

      $display("tests passed %0d failed %0d, %0d mismatches",
               passCount, failCount, errCount);
      if (failCount == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

//--- tb.f
+incdir+.
mipsPkg.sv
ctrlIf.sv
aluUnit.sv
regFile.sv
datapath.sv
mainController.sv
miniMips.sv
tbMiniMips.sv

//--- run.sh
#!/bin/sh
# compile and run the mips core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tbMiniMips -o simMiniMips

out=$(./obj_dir/simMiniMips)
echo "$out"

# pass only when the testbench reports it
echo "$out" | grep -qx "Result: PASSED"
